// ==== sim.f ====
source/periph_pkg.sv
source/periph_bus_arbiter.sv
source/plic.sv
source/machine_timer.sv
source/periph_subsystem.sv
dv/periph_subsystem_chk.sv
dv/periph_subsystem_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --assert --timing -j 0
TOP      := periph_subsystem_tb
FILELIST := sim.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/periph_subsystem_tb.sv ====
`default_nettype none

module periph_subsystem_tb;

    import periph_pkg::*;

    localparam int irq_cnt = 7;
    localparam int id_w = $clog2(irq_cnt + 1);
    localparam int n_reg = 12;
    localparam int n_irq = 96;
    localparam int n_arb = 8;
    localparam int test_cycles = 16 + 6 * n_reg + 7 * n_irq + 60 + 5 * n_arb;
    localparam int max_cycles = 4 * test_cycles;
    // Bits 1 to irq_cnt of the ip and ie registers.
    localparam logic [data_w-1:0] ie_mask = data_w'(((1 << irq_cnt) - 1) << 1);

    logic                        clk = 1'b0;
    logic                        reset;
    logic [1:0]                  req;
    logic [1:0][3:0]             we;
    logic [1:0][addr_w-1:0]      addr;
    logic [1:0][data_w-1:0]      wdata;
    wire logic [1:0]             gnt;
    wire logic [1:0]             rvalid;
    wire logic [1:0][data_w-1:0] rdata;
    logic [irq_cnt:2]            ext_irq;
    logic                        iack;
    wire logic                   irq;
    wire logic [id_w-1:0]        id;
    wire logic [irq_cnt:1]       iack_out;

    logic [31:0]      rng = 32'h041b_d902;
    logic [irq_cnt:1] ip_model;
    logic [irq_cnt:1] ie_model;
    logic             last_gnt;
    logic             gnt_seen = 1'b0;
    int               cycles = 0;

    periph_subsystem #(
        .irq_cnt (irq_cnt)
    ) periph_subsystem_inst (
        .clk         (clk),
        .reset       (reset),
        .m0_req_i    (req[0]),
        .m0_we_i     (we[0]),
        .m0_addr_i   (addr[0]),
        .m0_wdata_i  (wdata[0]),
        .m0_gnt_o    (gnt[0]),
        .m0_rdata_o  (rdata[0]),
        .m0_rvalid_o (rvalid[0]),
        .m1_req_i    (req[1]),
        .m1_we_i     (we[1]),
        .m1_addr_i   (addr[1]),
        .m1_wdata_i  (wdata[1]),
        .m1_gnt_o    (gnt[1]),
        .m1_rdata_o  (rdata[1]),
        .m1_rvalid_o (rvalid[1]),
        .ext_irq_i   (ext_irq),
        .iack_i      (iack),
        .irq_o       (irq),
        .id_o        (id),
        .iack_o      (iack_out)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Lowest pending enabled source wins. Returns {irq, id, one-hot ack}.
    function automatic logic [irq_cnt+id_w:0] irq_ref(input logic [irq_cnt:1] ip_v,
            input logic [irq_cnt:1] ie_v, input logic ack);
        logic [irq_cnt:1] act;
        logic [id_w-1:0]  sel;
        logic [irq_cnt:1] onehot;
        act = ip_v & ie_v;
        sel = '0;
        onehot = '0;
        for (int i = 1; i <= irq_cnt; i++) begin
            if (act[i] && sel == '0) begin
                sel = id_w'(i);
            end
        end
        if (ack && sel != '0) begin
            onehot[sel] = 1'b1;
        end
        return {(|act) & ~ack, sel, onehot};
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
        if (got !== want) begin
            $display("ERROR at time %0t: %s, got %0h, expected %0h", $time, what, got, want);
            $display("=== FAIL ===");
            $fatal(1, "Stopped at the first mismatch.");
        end
    endtask

    // Entered and left just after a falling edge.
    task automatic bus_access(input int m, input logic [3:0] wr, input logic [addr_w-1:0] a,
            input logic [data_w-1:0] d, output logic [data_w-1:0] q);
        req[m] = 1'b1;
        we[m] = wr;
        addr[m] = a;
        wdata[m] = d;
        q = '0;
        @(posedge clk);
        while (!gnt[m]) begin
            @(posedge clk);
        end
        @(negedge clk);
        req[m] = 1'b0;
        we[m] = 4'b0000;
        if (wr == 4'b0000) begin
            @(posedge clk);
            check(32'(rvalid[m]), 32'd1, "rvalid one cycle after read grant");
            q = rdata[m];
            @(negedge clk);
        end
    endtask

    task automatic write_reg(input int m, input logic [addr_w-1:0] a,
            input logic [data_w-1:0] d);
        logic [data_w-1:0] unused;
        bus_access(m, 4'b1111, a, d, unused);
    endtask

    task automatic read_check(input int m, input logic [addr_w-1:0] a,
            input logic [data_w-1:0] want, input string what);
        logic [data_w-1:0] q;
        bus_access(m, 4'b0000, a, '0, q);
        check(q, want, what);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("Simulation hung: no verdict after %0d cycles.", cycles);
            $display("=== FAIL ===");
            $fatal(1, "Timeout.");
        end
    end

    // The ip model is the source vector seen one edge earlier.
    always @(posedge clk) begin : compare
        logic [irq_cnt+id_w:0] want;
        if (reset) begin
            ip_model = '0;
            ie_model = '0;
        end
        else begin
            want = irq_ref(ip_model, ie_model, iack);
            check(32'(irq), 32'(want[irq_cnt+id_w]), "irq_o");
            check(32'(id), 32'(want[irq_cnt+id_w-1:irq_cnt]), "id_o");
            check(32'(iack_out), 32'(want[irq_cnt-1:0]), "iack_o");
            if (req == 2'b11 && gnt_seen) begin
                check(32'(gnt), last_gnt ? 32'd1 : 32'd2, "round-robin grant");
            end
            for (int m = 0; m < 2; m++) begin
                if (gnt[m]) begin
                    last_gnt = (m == 1);
                    gnt_seen = 1'b1;
                    if (we[m] != 4'b0000 && addr[m] == plic_ie_off) begin
                        ie_model = wdata[m][irq_cnt:1];
                    end
                end
            end
            ip_model = {ext_irq, periph_subsystem_inst.timer_irq};
        end
    end

    initial begin
        logic [data_w-1:0] v;
        logic [data_w-1:0] t0;
        logic [data_w-1:0] t1;
        reset = 1'b1;
        req = '0;
        we = '0;
        addr = '0;
        wdata = '0;
        ext_irq = '0;
        iack = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Enable register written by one master, read back by the other.
        for (int i = 0; i < n_reg; i++) begin
            rng = xorshift(rng);
            v = rng;
            bus_access(i % 2, rng[3:0] | 4'b0001, plic_ie_off, v, t0);
            read_check((i + 1) % 2, plic_ie_off, v & ie_mask, "ie readback");
        end
        read_check(0, 24'h003000, '0, "unmapped plic offset");
        read_check(1, 24'h010004, '0, "unmapped timer offset");

        // Random sources, masks and acknowledges.
        for (int i = 0; i < n_irq; i++) begin
            rng = xorshift(rng);
            ext_irq = (i % 5 == 0) ? '0 : rng[irq_cnt:2];
            iack = rng[20];
            if (i % 8 == 0) begin
                write_reg(0, plic_ie_off, rng >> 8);
            end
            @(negedge clk);
            // Bit 1 is the timer source, still quiet here.
            if (i % 4 == 3) begin
                read_check(1, plic_ip_off, data_w'({ext_irq, 2'b00}), "ip readback");
            end
        end
        iack = 1'b0;
        ext_irq = '1;
        write_reg(0, plic_ie_off, ie_mask);

        // Timer.
        bus_access(0, 4'b0000, timer_mtime_off, '0, t0);
        bus_access(1, 4'b0000, timer_mtime_off, '0, t1);
        check(32'(t1 > t0), 32'd1, "mtime advances");
        write_reg(1, timer_cmp_off, t1 + 32'h0010_0000);
        repeat (4) @(negedge clk);
        check(32'(id), 32'd2, "far compare gives no timer id");
        write_reg(1, timer_cmp_off, '0);
        @(negedge clk);
        check(32'(id), 32'd2, "timer id before its latency");
        @(negedge clk);
        check(32'(id), 32'd1, "timer id after compare write");
        check(32'(irq), 32'd1, "irq_o after compare write");
        write_reg(0, timer_mtime_off, 32'hf000_0000);
        write_reg(1, timer_cmp_off, 32'h8000_0000);
        repeat (3) @(negedge clk);
        check(32'(id), 32'd1, "timer id with mtime past compare");
        write_reg(0, timer_mtime_off, '0);
        repeat (3) @(negedge clk);
        check(32'(id), 32'd2, "mtime write clears timer interrupt");
        read_check(1, timer_cmp_off, 32'h8000_0000, "mtimecmp readback");
        ext_irq = '0;

        // Both masters read in the same cycles.
        for (int i = 0; i < n_arb; i++) begin
            // A lone m0 read first hands the next tie to m1.
            if (i % 2 == 1) begin
                read_check(0, timer_cmp_off, 32'h8000_0000, "m0 read before contention");
            end
            fork
                bus_access(0, 4'b0000, (i % 2 == 1) ? timer_cmp_off : plic_ie_off, '0, t0);
                bus_access(1, 4'b0000, (i % 2 == 1) ? plic_ie_off : timer_cmp_off, '0, t1);
            join
            check(t0, (i % 2 == 1) ? 32'h8000_0000 : ie_mask, "m0 read under contention");
            check(t1, (i % 2 == 1) ? ie_mask : 32'h8000_0000, "m1 read under contention");
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/periph_subsystem_chk.sv ====
`default_nettype none

module periph_subsystem_chk (
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       m0_req_i,
    input wire logic       m1_req_i,
    input wire logic       m0_gnt_o,
    input wire logic       m1_gnt_o,
    input wire logic       m0_rvalid_o,
    input wire logic       m1_rvalid_o,
    input wire logic [3:0] bus_we,
    input wire logic       irq_o,
    input wire logic       iack_i
);

    grant_single: assert property (@(posedge clk) disable iff (reset)
        !(m0_gnt_o && m1_gnt_o))
        else $error("Both masters granted in one cycle.");

    grant_needs_req: assert property (@(posedge clk) disable iff (reset)
        (!m0_gnt_o || m0_req_i) && (!m1_gnt_o || m1_req_i))
        else $error("Grant without a request.");

    // Read data returns exactly one cycle after a read grant.
    m0_rvalid_timing: assert property (@(posedge clk) disable iff (reset)
        m0_rvalid_o == $past(m0_gnt_o && bus_we == 4'b0000))
        else $error("m0 rvalid does not follow its read grant.");

    m1_rvalid_timing: assert property (@(posedge clk) disable iff (reset)
        m1_rvalid_o == $past(m1_gnt_o && bus_we == 4'b0000))
        else $error("m1 rvalid does not follow its read grant.");

    irq_quiet_in_ack: assert property (@(posedge clk) disable iff (reset)
        iack_i |-> !irq_o)
        else $error("irq_o high during acknowledge.");

endmodule

bind periph_subsystem periph_subsystem_chk periph_subsystem_chk_inst (
    .clk         (clk),
    .reset       (reset),
    .m0_req_i    (m0_req_i),
    .m1_req_i    (m1_req_i),
    .m0_gnt_o    (m0_gnt_o),
    .m1_gnt_o    (m1_gnt_o),
    .m0_rvalid_o (m0_rvalid_o),
    .m1_rvalid_o (m1_rvalid_o),
    .bus_we      (bus_we),
    .irq_o       (irq_o),
    .iack_i      (iack_i)
);

`default_nettype wire

// ==== source/periph_subsystem.sv ====
`default_nettype none

module periph_subsystem #(
    parameter int irq_cnt = 7
) (
    input  wire logic                          clk,
    input  wire logic                          reset,

    // Core data port.
    input  wire logic                          m0_req_i,
    input  wire logic [3:0]                    m0_we_i,
    input  wire logic [periph_pkg::addr_w-1:0] m0_addr_i,
    input  wire logic [periph_pkg::data_w-1:0] m0_wdata_i,
    output logic                               m0_gnt_o,
    output logic [periph_pkg::data_w-1:0]      m0_rdata_o,
    output logic                               m0_rvalid_o,

    // Host port.
    input  wire logic                          m1_req_i,
    input  wire logic [3:0]                    m1_we_i,
    input  wire logic [periph_pkg::addr_w-1:0] m1_addr_i,
    input  wire logic [periph_pkg::data_w-1:0] m1_wdata_i,
    output logic                               m1_gnt_o,
    output logic [periph_pkg::data_w-1:0]      m1_rdata_o,
    output logic                               m1_rvalid_o,

    input  wire logic [irq_cnt:2]              ext_irq_i,
    input  wire logic                          iack_i,
    output logic                               irq_o,
    output logic [$clog2(irq_cnt+1)-1:0]       id_o,
    output logic [irq_cnt:1]                   iack_o
);

    import periph_pkg::*;

    logic              plic_en;
    logic              timer_en;
    logic [3:0]        bus_we;
    logic [addr_w-1:0] bus_addr;
    logic [data_w-1:0] bus_wdata;
    logic [data_w-1:0] plic_rdata;
    logic [data_w-1:0] timer_rdata;
    logic              timer_irq;
    logic [irq_cnt:1]  irq_vec;

    // Source 1 is the timer, the rest come from pins.
    assign irq_vec = {ext_irq_i, timer_irq};

    periph_bus_arbiter periph_bus_arbiter_inst (
        .clk           (clk),
        .reset         (reset),
        .m0_req_i      (m0_req_i),
        .m0_we_i       (m0_we_i),
        .m0_addr_i     (m0_addr_i),
        .m0_wdata_i    (m0_wdata_i),
        .m0_gnt_o      (m0_gnt_o),
        .m0_rdata_o    (m0_rdata_o),
        .m0_rvalid_o   (m0_rvalid_o),
        .m1_req_i      (m1_req_i),
        .m1_we_i       (m1_we_i),
        .m1_addr_i     (m1_addr_i),
        .m1_wdata_i    (m1_wdata_i),
        .m1_gnt_o      (m1_gnt_o),
        .m1_rdata_o    (m1_rdata_o),
        .m1_rvalid_o   (m1_rvalid_o),
        .plic_rdata_i  (plic_rdata),
        .timer_rdata_i (timer_rdata),
        .plic_en_o     (plic_en),
        .timer_en_o    (timer_en),
        .bus_we_o      (bus_we),
        .bus_addr_o    (bus_addr),
        .bus_wdata_o   (bus_wdata)
    );

    plic #(
        .irq_cnt (irq_cnt)
    ) plic_inst (
        .clk    (clk),
        .reset  (reset),
        .en_i   (plic_en),
        .we_i   (bus_we),
        .addr_i (bus_addr),
        .data_i (bus_wdata),
        .data_o (plic_rdata),
        .irq_i  (irq_vec),
        .iack_i (iack_i),
        .iack_o (iack_o),
        .irq_o  (irq_o),
        .id_o   (id_o)
    );

    machine_timer machine_timer_inst (
        .clk         (clk),
        .reset       (reset),
        .en_i        (timer_en),
        .we_i        (bus_we),
        .addr_i      (bus_addr),
        .data_i      (bus_wdata),
        .data_o      (timer_rdata),
        .timer_irq_o (timer_irq)
    );

endmodule

`default_nettype wire

// ==== source/machine_timer.sv ====
`default_nettype none

module machine_timer (
    input  wire logic                          clk,
    input  wire logic                          reset,

    input  wire logic                          en_i,
    input  wire logic [3:0]                    we_i,
    input  wire logic [periph_pkg::addr_w-1:0] addr_i,
    input  wire logic [periph_pkg::data_w-1:0] data_i,
    output logic [periph_pkg::data_w-1:0]      data_o,

    output logic                               timer_irq_o
);

    import periph_pkg::*;

    logic [data_w-1:0] mtime;
    logic [data_w-1:0] mtimecmp;
    logic              bus_wr;
    logic              bus_rd;
    logic              mtime_wr;
    logic              cmp_wr;

    assign bus_wr = en_i & (we_i != 4'b0000);
    assign bus_rd = en_i & (we_i == 4'b0000);

    assign mtime_wr = bus_wr & (addr_i == timer_mtime_off);
    assign cmp_wr   = bus_wr & (addr_i == timer_cmp_off);

    // Free-running counter.
    // A write replaces the increment for that cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            mtime <= '0;
        end
        else if (mtime_wr) begin
            mtime <= data_i;
        end
        else begin
            mtime <= mtime + 1'b1;
        end
    end

    // All ones keeps the interrupt quiet out of reset.
    always_ff @(posedge clk) begin
        if (reset) begin
            mtimecmp <= '1;
        end
        else if (cmp_wr) begin
            mtimecmp <= data_i;
        end
    end

    // Compare result, one cycle behind the registers.
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_irq_o <= 1'b0;
        end
        else begin
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    // Read data.
    always_ff @(posedge clk) begin
        if (reset) begin
            data_o <= '0;
        end
        else if (bus_rd) begin
            case (addr_i)
                timer_mtime_off: data_o <= mtime;
                timer_cmp_off:   data_o <= mtimecmp;
                default:         data_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/plic.sv ====
`default_nettype none

module plic #(
    parameter int irq_cnt = 7
) (
    input  wire logic                          clk,
    input  wire logic                          reset,

    input  wire logic                          en_i,
    input  wire logic [3:0]                    we_i,
    input  wire logic [periph_pkg::addr_w-1:0] addr_i,
    input  wire logic [periph_pkg::data_w-1:0] data_i,
    output logic [periph_pkg::data_w-1:0]      data_o,

    input  wire logic [irq_cnt:1]              irq_i,
    input  wire logic                          iack_i,

    output logic [irq_cnt:1]                   iack_o,
    output logic                               irq_o,
    output logic [$clog2(irq_cnt+1)-1:0]       id_o
);

    import periph_pkg::*;

    localparam int id_w = $clog2(irq_cnt + 1);

    logic [irq_cnt:1] ip;
    logic [irq_cnt:1] ie;
    logic [irq_cnt:1] active;
    logic             bus_wr;
    logic             bus_rd;

    // Sources are sampled once per cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            ip <= '0;
        end
        else begin
            ip <= irq_i;
        end
    end

    assign active = ip & ie;

    // Lowest pending index wins. Zero means nothing pending.
    always_comb begin
        id_o = '0;
        for (int i = irq_cnt; i >= 1; i--) begin
            if (active[i]) begin
                id_o = id_w'(i);
            end
        end
    end

    assign irq_o = (|active) & ~iack_i;

    always_comb begin
        for (int i = 1; i <= irq_cnt; i++) begin
            iack_o[i] = iack_i & (id_o == id_w'(i));
        end
    end

    // Register access.
    // Any nonzero strobe writes the whole word.
    assign bus_wr = en_i & (we_i != 4'b0000);
    assign bus_rd = en_i & (we_i == 4'b0000);

    always_ff @(posedge clk) begin
        if (reset) begin
            ie <= '0;
        end
        else if (bus_wr && addr_i == plic_ie_off) begin
            ie <= data_i[irq_cnt:1];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_o <= '0;
        end
        else if (bus_rd) begin
            case (addr_i)
                plic_ip_off: data_o <= data_w'({ip, 1'b0});
                plic_ie_off: data_o <= data_w'({ie, 1'b0});
                default:     data_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/periph_bus_arbiter.sv ====
`default_nettype none

module periph_bus_arbiter (
    input  wire logic                          clk,
    input  wire logic                          reset,

    input  wire logic                          m0_req_i,
    input  wire logic [3:0]                    m0_we_i,
    input  wire logic [periph_pkg::addr_w-1:0] m0_addr_i,
    input  wire logic [periph_pkg::data_w-1:0] m0_wdata_i,
    output logic                               m0_gnt_o,
    output logic [periph_pkg::data_w-1:0]      m0_rdata_o,
    output logic                               m0_rvalid_o,

    input  wire logic                          m1_req_i,
    input  wire logic [3:0]                    m1_we_i,
    input  wire logic [periph_pkg::addr_w-1:0] m1_addr_i,
    input  wire logic [periph_pkg::data_w-1:0] m1_wdata_i,
    output logic                               m1_gnt_o,
    output logic [periph_pkg::data_w-1:0]      m1_rdata_o,
    output logic                               m1_rvalid_o,

    input  wire logic [periph_pkg::data_w-1:0] plic_rdata_i,
    input  wire logic [periph_pkg::data_w-1:0] timer_rdata_i,
    output logic                               plic_en_o,
    output logic                               timer_en_o,
    output logic [3:0]                         bus_we_o,
    output logic [periph_pkg::addr_w-1:0]      bus_addr_o,
    output logic [periph_pkg::data_w-1:0]      bus_wdata_o
);

    import periph_pkg::*;

    localparam int sel_w = $clog2(n_masters);
    localparam logic [sel_w-1:0] m0_idx = '0;
    localparam logic [sel_w-1:0] m1_idx = sel_w'(1);

    logic [sel_w-1:0]  last_gnt;
    logic [sel_w-1:0]  gnt_idx;
    logic              any_gnt;

    // Read return record, valid for one cycle after a read grant.
    logic              rd_pend;
    logic [sel_w-1:0]  rd_master;
    logic              rd_region;
    logic [data_w-1:0] rd_data;

    // A lone requester wins at once; on a tie the master not granted last wins.
    assign m0_gnt_o = m0_req_i & (~m1_req_i | (last_gnt == m1_idx));
    assign m1_gnt_o = m1_req_i & (~m0_req_i | (last_gnt == m0_idx));

    assign any_gnt = m0_gnt_o | m1_gnt_o;
    assign gnt_idx = m1_gnt_o ? m1_idx : m0_idx;

    always_comb begin
        if (gnt_idx == m1_idx) begin
            bus_we_o    = m1_we_i;
            bus_addr_o  = m1_addr_i;
            bus_wdata_o = m1_wdata_i;
        end
        else begin
            bus_we_o    = m0_we_i;
            bus_addr_o  = m0_addr_i;
            bus_wdata_o = m0_wdata_i;
        end
    end

    // Region decode.
    assign plic_en_o  = any_gnt & ~bus_addr_o[region_bit];
    assign timer_en_o = any_gnt & bus_addr_o[region_bit];

    always_ff @(posedge clk) begin
        if (reset) begin
            last_gnt <= m1_idx;
        end
        else if (any_gnt) begin
            last_gnt <= gnt_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_pend   <= 1'b0;
            rd_master <= m0_idx;
            rd_region <= 1'b0;
        end
        else begin
            rd_pend   <= any_gnt & (bus_we_o == 4'b0000);
            rd_master <= gnt_idx;
            rd_region <= bus_addr_o[region_bit];
        end
    end

    // Steer the registered peripheral word back to the master that asked.
    assign rd_data = rd_region ? timer_rdata_i : plic_rdata_i;

    assign m0_rvalid_o = rd_pend & (rd_master == m0_idx);
    assign m1_rvalid_o = rd_pend & (rd_master == m1_idx);

    assign m0_rdata_o = m0_rvalid_o ? rd_data : '0;
    assign m1_rdata_o = m1_rvalid_o ? rd_data : '0;

endmodule

`default_nettype wire

// ==== source/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // Bus widths.
    localparam int addr_w = 24;
    localparam int data_w = 32;

    // Core data port and host port.
    localparam int n_masters = 2;

    // Address bit that splits the map into the plic and timer regions.
    localparam int region_bit = 16;

    // Interrupt controller registers, region 0.
    // Pending register is read-only.
    localparam logic [addr_w-1:0] plic_ip_off = 24'h001000;
    localparam logic [addr_w-1:0] plic_ie_off = 24'h002000;

    // Machine timer registers, region 1.
    // Writing mtime loads the counter.
    localparam logic [addr_w-1:0] timer_mtime_off = 24'h010000;
    localparam logic [addr_w-1:0] timer_cmp_off   = 24'h010008;

endpackage

`default_nettype wire
